// ==== bench/wb_asserts.sv ====
module wb_asserts (
    input logic clk,
    input logic reset,
    input logic ws_valid,
    input logic ws_allowin,
    input logic rf_we,
    input logic ws_ex
);

    int fail_count = 0;

    we_needs_valid: assert property (@(posedge clk) disable iff (reset) rf_we |-> ws_valid)
        else begin
            fail_count++;
            $error("register file write with no valid item in the stage");
        end

    // an excepting item must not reach the register file
    no_we_on_ex: assert property (@(posedge clk) disable iff (reset) ws_ex |-> !rf_we)
        else begin
            fail_count++;
            $error("register file write from an instruction that took an exception");
        end

    allowin_high: assert property (@(posedge clk) disable iff (reset) ws_allowin)
        else begin
            fail_count++;
            $error("write-back stage refused an item after reset");
        end

endmodule

// ==== bench/wb_checker.sv ====
module wb_checker (
    input  logic                    clk,
    input  logic                    check_en,
    input  logic [wb_pkg::xlen-1:0] rs_data,
    input  logic [wb_pkg::xlen-1:0] rt_data,
    input  logic                    flush,
    input  logic [wb_pkg::xlen-1:0] flush_pc,
    input  logic                    ws_ex,
    input  logic [wb_pkg::xlen-1:0] cp0_epc,
    input  logic                    cp0_status_exl,
    input  logic                    int_pending,
    input  logic [wb_pkg::xlen-1:0] exp_rs,
    input  logic [wb_pkg::xlen-1:0] exp_rt,
    input  logic                    exp_flush,
    input  logic [wb_pkg::xlen-1:0] exp_flush_pc,
    input  logic                    exp_ex,
    input  logic [wb_pkg::xlen-1:0] exp_epc,
    input  logic                    exp_exl,
    input  logic                    exp_int,
    output int                      errors,
    output int                      checks
);
    import wb_pkg::*;

    initial begin
        errors = 0;
        checks = 0;
    end

    task automatic compare_value(input string name, input logic [xlen-1:0] expected,
                                 input logic [xlen-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h at time %0t",
                     name, expected, actual, $time);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (check_en) begin
            compare_value("reg_read_rs", exp_rs, rs_data);
            compare_value("reg_read_rt", exp_rt, rt_data);
            compare_value("flush", xlen'(exp_flush), xlen'(flush));
            if (exp_flush)
                compare_value("flush_pc", exp_flush_pc, flush_pc);
            compare_value("ws_ex", xlen'(exp_ex), xlen'(ws_ex));
            compare_value("cp0_epc", exp_epc, cp0_epc);
            compare_value("status_exl", xlen'(exp_exl), xlen'(cp0_status_exl));
            compare_value("int_pending", xlen'(exp_int), xlen'(int_pending));
        end
    end

endmodule

// ==== bench/wb_tb.sv ====
module wb_tb;
    import wb_pkg::*;

    localparam int n_preamble     = 33;             // compare, epc, then r1..r31
    localparam int n_items        = n_preamble + 400;
    localparam int timeout_cycles = n_items * 4 + 100;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] result;
        logic [4:0]      dest;
        logic            gr_we;
        logic            mfc0;
        logic            mtc0;
        logic            eret;
        cp0_reg_e        cp0;
        logic            ex;
        exc_code_e       code;
        logic            bd;
        logic [xlen-1:0] bad;
    } item_t;

    logic            clk, reset, ws_allowin, flush, ws_ex, cp0_status_exl, int_pending;
    logic [5:0]      ext_int;
    logic [4:0]      rs_addr, rt_addr;
    logic [xlen-1:0] rs_data, rt_data, flush_pc, cp0_epc;
    item_t           cur;                           // item on the memory-stage ports
    item_t           st;                            // model copy of the stage register
    item_t           idle_item;

    logic [xlen-1:0] m_regs [32];
    bit              reg_known [32];
    logic            m_ie, m_exl, m_bd;
    logic [7:0]      m_im, m_ip;
    exc_code_e       m_exc;
    logic [xlen-1:0] m_epc, m_badvaddr, m_compare;
    bit              epc_known, bad_known;
    logic [4:0]      last_dest;
    logic [31:0]     lcg_state = 32'hfa84_92ef;
    logic            check_en, exp_flush, exp_ex, exp_exl, exp_int;
    logic [xlen-1:0] exp_rs, exp_rt, exp_flush_pc, exp_epc;
    int              errors, checks, assert_fails;
    exc_code_e       exc_list [7] = '{exc_int, exc_adel, exc_ades, exc_sys, exc_bp, exc_ri, exc_ov};
    cp0_reg_e        cp0_list [5] = '{c0_epc, c0_compare, c0_status, c0_cause, c0_badvaddr};

    wb_top #(
        .count_div(2)
    ) i_wb_top (
        .ms_valid    (cur.valid),
        .ms_pc       (cur.pc),
        .ms_result   (cur.result),
        .ms_dest     (cur.dest),
        .ms_gr_we    (cur.gr_we),
        .ms_inst_mfc0(cur.mfc0),
        .ms_inst_mtc0(cur.mtc0),
        .ms_inst_eret(cur.eret),
        .ms_cp0_addr (cur.cp0),
        .ms_ex       (cur.ex),
        .ms_exc_code (cur.code),
        .ms_bd       (cur.bd),
        .ms_bad_addr (cur.bad),
        .*
    );

    wb_checker i_wb_checker (.*);

    bind wb_stage wb_asserts i_wb_asserts (.*);

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic item_t make_item(int n);
        item_t       it;
        logic [31:0] r;
        logic [31:0] pc;
        r         = lcg_next();
        pc        = lcg_next();
        it.valid  = (n < n_preamble) || (r[2:0] != 3'd0);
        it.pc     = {pc[31:2], 2'b00};
        it.result = lcg_next();
        it.bad    = lcg_next();
        it.dest   = r[8:4];
        it.gr_we  = r[9] | r[10];                   // mostly writes
        it.ex     = (r[13:11] == 3'd0);
        it.code   = exc_list[r[16:14] % 7];
        it.bd     = r[17];
        it.mfc0   = (r[20:18] == 3'd2);
        it.mtc0   = (r[20:18] <= 3'd1);
        it.eret   = (r[20:18] == 3'd3);
        it.cp0    = cp0_list[it.mtc0 ? r[22:21] : r[25:23] % 5];
        if (it.mfc0 && it.cp0 == c0_badvaddr && !bad_known)
            it.cp0 = c0_status;                     // nothing latched there yet
        if (it.mtc0 || it.eret)
            it.gr_we = 1'b0;
        if (it.mfc0)
            it.gr_we = 1'b1;
        if (n < n_preamble) begin
            it.ex    = 1'b0;
            it.mfc0  = 1'b0;
            it.eret  = 1'b0;
            it.mtc0  = (n < 2);
            it.gr_we = (n >= 2);
            it.cp0   = (n == 0) ? c0_compare : c0_epc;
            it.dest  = 5'(n - 1);
        end
        if (it.mtc0 && it.cp0 == c0_compare)
            it.result[31] = 1'b1;                   // keeps compare far above count
        return it;
    endfunction

    function automatic logic [31:0] cp0_read(cp0_reg_e a);
        logic [31:0] v;
        v = '0;
        case (a)
            c0_badvaddr: v = m_badvaddr;
            c0_compare:  v = m_compare;
            c0_epc:      v = m_epc;
            c0_status:   v = {16'h0, m_im, 6'h0, m_exl, m_ie};
            c0_cause:    v = {m_bd, 15'h0, m_ip, 1'b0, m_exc, 2'b00};   // TI assumed clear
            default:     v = '0;
        endcase
        return v;
    endfunction

    task automatic cp0_write(cp0_reg_e a, logic [31:0] d);
        case (a)
            c0_status: begin
                m_ie  = d[0];
                m_exl = d[1];
                m_im  = d[15:8];
            end
            c0_cause:   m_ip[1:0] = d[9:8];        // software bits only
            c0_epc: begin
                m_epc     = d;
                epc_known = 1'b1;
            end
            c0_compare: m_compare = d;
            default:    ;
        endcase
    endtask

    task automatic model_step();
        logic        flush_now;
        logic [31:0] rd;
        exp_int   = m_ie && !m_exl && |(m_ip & m_im);     // registered one cycle late
        flush_now = st.valid && (st.ex || st.eret);
        if (st.valid && st.ex) begin
            if (!m_exl) begin
                m_epc     = st.bd ? st.pc - 32'd4 : st.pc;
                m_bd      = st.bd;
                epc_known = 1'b1;
            end
            m_exl = 1'b1;
            m_exc = st.code;
            if (st.code == exc_adel || st.code == exc_ades) begin
                m_badvaddr = st.bad;
                bad_known  = 1'b1;
            end
        end else if (st.valid) begin
            rd = st.mfc0 ? cp0_read(st.cp0) : st.result;
            if (st.gr_we && st.dest != 5'd0) begin
                m_regs[st.dest]    = rd;
                reg_known[st.dest] = 1'b1;
                last_dest          = st.dest;
            end
            if (st.eret)
                m_exl = 1'b0;
            if (st.mtc0)
                cp0_write(st.cp0, st.result);
        end
        m_ip[7:2] = ext_int;                        // hardware lines, timer idle
        st        = cur;
        st.valid  = cur.valid && !flush_now;        // dropped behind a flush
    endtask

    task automatic drive_cycle(int n);
        logic [31:0] r;
        logic [4:0]  rs_sel;
        r      = lcg_next();
        rs_sel = reg_known[r[4:0]] ? r[4:0] : 5'd0;
        if (n < n_items)
            cur <= make_item(n);
        else
            cur <= idle_item;
        ext_int      <= r[13:8];
        rs_addr      <= rs_sel;
        rt_addr      <= last_dest;                  // most recent write
        exp_rs       = m_regs[rs_sel];
        exp_rt       = m_regs[last_dest];
        exp_flush    = st.valid && (st.ex || st.eret);
        exp_flush_pc = st.ex ? exc_vector : m_epc;
        exp_ex       = st.valid && st.ex;
        exp_epc      = m_epc;
        exp_exl      = m_exl;
        check_en     = epc_known;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the run was still going after %0d cycles", timeout_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        idle_item       = make_item(0);
        idle_item.valid = 1'b0;
        st              = idle_item;
        reset   <= 1'b1;
        cur     <= idle_item;
        ext_int <= '0;
        rs_addr <= '0;
        rt_addr <= '0;
        check_en  = 1'b0;
        m_ie      = 1'b0;
        m_exl     = 1'b0;
        m_bd      = 1'b0;
        m_im      = '0;
        m_ip      = '0;
        m_exc     = exc_int;
        m_regs[0] = '0;
        reg_known[0] = 1'b1;
        last_dest = '0;
        exp_int   = 1'b0;
        exp_ex    = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        drive_cycle(0);
        for (int n = 1; n <= n_items + 1; n++) begin
            @(posedge clk);
            model_step();
            drive_cycle(n);
        end
        @(posedge clk);
        assert_fails = i_wb_top.i_wb_stage.i_wb_asserts.fail_count;
        if (checks == 0)
            $display("no output was ever compared, checking never got enabled");
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 checks, errors, assert_fails);
        if (checks > 0 && errors == 0 && assert_fails == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
src/wb_pkg.sv
src/cp0_regs.sv
src/wb_stage.sv
src/reg_file.sv
src/wb_top.sv
bench/wb_asserts.sv
bench/wb_checker.sv
bench/wb_tb.sv

// ==== src/cp0_regs.sv ====
module cp0_regs #(
    parameter int count_div = 2
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    commit_mtc0,
    input  logic                    commit_ex,
    input  logic                    commit_eret,
    input  logic [wb_pkg::xlen-1:0] ws_pc,
    input  logic                    ws_bd,
    input  wb_pkg::exc_code_e       ws_exc_code,
    input  logic [wb_pkg::xlen-1:0] ws_bad_addr,
    input  wb_pkg::cp0_reg_e        cp0_addr,
    input  logic [wb_pkg::xlen-1:0] cp0_wdata,
    input  logic [5:0]              ext_int,
    output logic [wb_pkg::xlen-1:0] cp0_rdata,
    output logic [wb_pkg::xlen-1:0] cp0_epc,
    output logic                    cp0_status_exl,
    output logic                    int_pending
);
    import wb_pkg::*;

    localparam int div_w = (count_div > 1) ? $clog2(count_div) : 1;

    logic            status_ie;
    logic            status_exl;
    logic [7:0]      status_im;
    logic            cause_bd;
    logic            cause_ti;
    logic [7:0]      cause_ip;
    exc_code_e       cause_exc;
    logic [xlen-1:0] epc;
    logic [xlen-1:0] badvaddr;
    logic [xlen-1:0] count;
    logic [xlen-1:0] compare;
    logic [div_w-1:0] div_cnt;
    logic            count_tick;
    logic            wr_status;
    logic            wr_cause;
    logic            wr_epc;
    logic            wr_count;
    logic            wr_compare;

    assign wr_status  = commit_mtc0 && (cp0_addr == c0_status);
    assign wr_cause   = commit_mtc0 && (cp0_addr == c0_cause);
    assign wr_epc     = commit_mtc0 && (cp0_addr == c0_epc);
    assign wr_count   = commit_mtc0 && (cp0_addr == c0_count);
    assign wr_compare = commit_mtc0 && (cp0_addr == c0_compare);

    always_ff @(posedge clk) begin
        if (reset) begin
            status_ie  <= 1'b0;
            status_exl <= 1'b0;
            status_im  <= 8'h00;
        end else if (commit_ex) begin
            status_exl <= 1'b1;                 // enter exception level
        end else if (commit_eret) begin
            status_exl <= 1'b0;
        end else if (wr_status) begin
            status_ie  <= cp0_wdata[status_ie_bit];
            status_exl <= cp0_wdata[status_exl_bit];
            status_im  <= cp0_wdata[status_im_lo +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd  <= 1'b0;
            cause_ti  <= 1'b0;
            cause_ip  <= 8'h00;
            cause_exc <= exc_int;
        end else begin
            // hardware lines, timer folded into IP7
            cause_ip[7:2] <= {ext_int[5] | cause_ti, ext_int[4:0]};
            if (wr_cause) begin
                cause_ip[1:0] <= cp0_wdata[cause_ip_lo +: 2];  // software interrupts
            end
            if (wr_compare) begin
                cause_ti <= 1'b0;               // compare write acks timer
            end else if (count == compare) begin
                cause_ti <= 1'b1;
            end
            if (commit_ex) begin
                cause_exc <= ws_exc_code;
                if (!status_exl) begin
                    cause_bd <= ws_bd;          // only on first-level entry
                end
            end
        end
    end

    // EPC is held while already at exception level
    always_ff @(posedge clk) begin
        if (commit_ex && !status_exl) begin
            epc <= ws_bd ? ws_pc - xlen'(4) : ws_pc;
        end else if (wr_epc) begin
            epc <= cp0_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_ex && (ws_exc_code == exc_adel || ws_exc_code == exc_ades)) begin
            badvaddr <= ws_bad_addr;
        end
    end

    assign count_tick = (div_cnt == div_w'(count_div - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            count   <= '0;
        end else begin
            div_cnt <= count_tick ? '0 : div_cnt + 1'b1;
            if (wr_count) begin
                count <= cp0_wdata;
            end else if (count_tick) begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_compare) begin
            compare <= cp0_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            int_pending <= 1'b0;
        end else begin
            int_pending <= status_ie && !status_exl && |(cause_ip & status_im);
        end
    end

    always_comb begin
        cp0_rdata = '0;
        case (cp0_addr)
            c0_badvaddr: cp0_rdata = badvaddr;
            c0_count:    cp0_rdata = count;
            c0_compare:  cp0_rdata = compare;
            c0_status: begin
                cp0_rdata[status_ie_bit]     = status_ie;
                cp0_rdata[status_exl_bit]    = status_exl;
                cp0_rdata[status_im_lo +: 8] = status_im;
            end
            c0_cause: begin
                cp0_rdata[cause_bd_bit]      = cause_bd;
                cp0_rdata[cause_ti_bit]      = cause_ti;
                cp0_rdata[cause_ip_lo +: 8]  = cause_ip;
                cp0_rdata[cause_exc_lo +: 5] = cause_exc;
            end
            c0_epc:      cp0_rdata = epc;
            default:     cp0_rdata = '0;
        endcase
    end

    assign cp0_epc        = epc;
    assign cp0_status_exl = status_exl;

endmodule

// ==== src/reg_file.sv ====
module reg_file (
    input  logic                          clk,
    input  logic                          we,
    input  logic [wb_pkg::reg_addr_w-1:0] waddr,
    input  logic [wb_pkg::xlen-1:0]       wdata,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr1,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr2,
    output logic [wb_pkg::xlen-1:0]       rdata1,
    output logic [wb_pkg::xlen-1:0]       rdata2
);
    import wb_pkg::*;

    localparam int depth = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [depth];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;               // $0 stays unwritten
        end
    end

    // same-cycle write is seen on the next cycle
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/wb_pkg.sv ====
package wb_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // exception entry with BEV set
    localparam logic [xlen-1:0] exc_vector = 32'hbfc0_0380;

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        exc_int  = 5'd0,
        exc_adel = 5'd4,    // load or fetch address error
        exc_ades = 5'd5,    // store address error
        exc_sys  = 5'd8,
        exc_bp   = 5'd9,
        exc_ri   = 5'd10,   // reserved instruction
        exc_ov   = 5'd12
    } exc_code_e;

    // CP0 register numbers, sel 0 only
    typedef enum logic [4:0] {
        c0_badvaddr = 5'd8,
        c0_count    = 5'd9,
        c0_compare  = 5'd11,
        c0_status   = 5'd12,
        c0_cause    = 5'd13,
        c0_epc      = 5'd14
    } cp0_reg_e;

    // Status field positions
    localparam int status_ie_bit  = 0;
    localparam int status_exl_bit = 1;
    localparam int status_im_lo   = 8;    // IM[7:0] at 15:8

    // Cause field positions
    localparam int cause_exc_lo = 2;      // ExcCode at 6:2
    localparam int cause_ip_lo  = 8;      // IP[7:0] at 15:8
    localparam int cause_ti_bit = 30;
    localparam int cause_bd_bit = 31;

endpackage

// ==== src/wb_stage.sv ====
module wb_stage (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ms_valid,
    input  logic [wb_pkg::xlen-1:0]       ms_pc,
    input  logic [wb_pkg::xlen-1:0]       ms_result,
    input  logic [wb_pkg::reg_addr_w-1:0] ms_dest,
    input  logic                          ms_gr_we,
    input  logic                          ms_inst_mfc0,
    input  logic                          ms_inst_mtc0,
    input  logic                          ms_inst_eret,
    input  wb_pkg::cp0_reg_e              ms_cp0_addr,
    input  logic                          ms_ex,
    input  wb_pkg::exc_code_e             ms_exc_code,
    input  logic                          ms_bd,
    input  logic [wb_pkg::xlen-1:0]       ms_bad_addr,
    output logic                          ws_allowin,
    input  logic [wb_pkg::xlen-1:0]       cp0_rdata,
    input  logic [wb_pkg::xlen-1:0]       cp0_epc,
    output logic                          commit_mtc0,
    output logic                          commit_ex,
    output logic                          commit_eret,
    output logic [wb_pkg::xlen-1:0]       ws_pc,
    output logic                          ws_bd,
    output wb_pkg::exc_code_e             ws_exc_code,
    output logic [wb_pkg::xlen-1:0]       ws_bad_addr,
    output wb_pkg::cp0_reg_e              cp0_addr,
    output logic [wb_pkg::xlen-1:0]       cp0_wdata,
    output logic                          rf_we,
    output logic [wb_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [wb_pkg::xlen-1:0]       rf_wdata,
    output logic                          flush,
    output logic [wb_pkg::xlen-1:0]       flush_pc,
    output logic                          ws_ex
);
    import wb_pkg::*;

    logic                  ws_valid;
    logic                  ms_accept;
    logic                  ws_gr_we;
    logic                  ws_inst_mfc0;
    logic                  ws_inst_mtc0;
    logic                  ws_inst_eret;
    logic                  ws_has_ex;
    logic [reg_addr_w-1:0] ws_dest;
    logic [xlen-1:0]       ws_result;

    assign ws_allowin  = 1'b1;                  // single-cycle stage, never stalls
    assign ms_accept   = ms_valid && ws_allowin && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (flush) begin
            ws_valid <= 1'b0;                   // upstream is flushed too
        end else if (ws_allowin) begin
            ws_valid <= ms_valid;
        end
    end

    // instruction kind flags
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ws_gr_we     <= 1'b0;
            ws_inst_mfc0 <= 1'b0;
            ws_inst_mtc0 <= 1'b0;
            ws_inst_eret <= 1'b0;
            ws_has_ex    <= 1'b0;
        end else if (ms_accept) begin
            ws_gr_we     <= ms_gr_we;
            ws_inst_mfc0 <= ms_inst_mfc0;
            ws_inst_mtc0 <= ms_inst_mtc0;
            ws_inst_eret <= ms_inst_eret;
            ws_has_ex    <= ms_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_accept) begin
            ws_pc       <= ms_pc;
            ws_result   <= ms_result;
            ws_dest     <= ms_dest;
            cp0_addr    <= ms_cp0_addr;
            ws_exc_code <= ms_exc_code;
            ws_bd       <= ms_bd;
            ws_bad_addr <= ms_bad_addr;
        end
    end

    // an excepting instruction commits nothing but the exception
    assign commit_ex   = ws_valid && ws_has_ex;
    assign commit_mtc0 = ws_valid && ws_inst_mtc0 && !ws_has_ex;
    assign commit_eret = ws_valid && ws_inst_eret && !ws_has_ex;
    assign cp0_wdata   = ws_result;             // rt value for mtc0

    assign rf_we    = ws_valid && ws_gr_we && !ws_has_ex;
    assign rf_waddr = ws_dest;
    assign rf_wdata = ws_inst_mfc0 ? cp0_rdata : ws_result;

    assign flush    = commit_ex || commit_eret;
    assign flush_pc = commit_ex ? exc_vector : cp0_epc;
    assign ws_ex    = commit_ex;

endmodule

// ==== src/wb_top.sv ====
module wb_top #(
    parameter int count_div = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          ms_valid,
    input  logic [wb_pkg::xlen-1:0]       ms_pc,
    input  logic [wb_pkg::xlen-1:0]       ms_result,
    input  logic [wb_pkg::reg_addr_w-1:0] ms_dest,
    input  logic                          ms_gr_we,
    input  logic                          ms_inst_mfc0,
    input  logic                          ms_inst_mtc0,
    input  logic                          ms_inst_eret,
    input  wb_pkg::cp0_reg_e              ms_cp0_addr,
    input  logic                          ms_ex,
    input  wb_pkg::exc_code_e             ms_exc_code,
    input  logic                          ms_bd,
    input  logic [wb_pkg::xlen-1:0]       ms_bad_addr,
    input  logic [5:0]                    ext_int,
    input  logic [wb_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [wb_pkg::reg_addr_w-1:0] rt_addr,
    output logic                          ws_allowin,
    output logic [wb_pkg::xlen-1:0]       rs_data,
    output logic [wb_pkg::xlen-1:0]       rt_data,
    output logic                          flush,
    output logic [wb_pkg::xlen-1:0]       flush_pc,
    output logic                          ws_ex,
    output logic [wb_pkg::xlen-1:0]       cp0_epc,
    output logic                          cp0_status_exl,
    output logic                          int_pending
);
    import wb_pkg::*;

    logic                  commit_mtc0;
    logic                  commit_ex;
    logic                  commit_eret;
    logic [xlen-1:0]       ws_pc;
    logic                  ws_bd;
    exc_code_e             ws_exc_code;
    logic [xlen-1:0]       ws_bad_addr;
    cp0_reg_e              cp0_addr;
    logic [xlen-1:0]       cp0_wdata;
    logic [xlen-1:0]       cp0_rdata;
    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;

    wb_stage i_wb_stage (.*);

    cp0_regs #(
        .count_div(count_div)
    ) i_cp0_regs (.*);

    reg_file i_reg_file (
        .clk   (clk),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata),
        .raddr1(rs_addr),               // decode-stage read ports
        .raddr2(rt_addr),
        .rdata1(rs_data),
        .rdata2(rt_data)
    );

endmodule
